// File: common/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

`define XLEN            32
`define ARCH_REGS       32
`define PHYS_REGS       64
`define AREG_W          5
`define PREG_W          6
`define PADDR_W         12

// apb map
`define ADDR_ISSUE      12'h000
`define ADDR_XREG_BASE  12'h100
`define ADDR_XREG_MASK  12'h07c     // x index sits in paddr[6:2]

`define MULDIV_CYCLES   32

// r-type encodings
`define OPC_OP          7'b0110011
`define F7_BASE         7'b0000000
`define F7_SUB          7'b0100000
`define F7_MULDIV       7'b0000001
`define F3_ADD          3'b000
`define F3_XOR          3'b100
`define F3_OR           3'b110
`define F3_AND          3'b111
`define F3_MUL          3'b000
`define F3_DIVU         3'b101
`define F3_REMU         3'b111

`endif

// File: common/ooo_pkg.sv
`include "ooo_consts.svh"

package ooo_pkg;

    typedef logic [`XLEN-1:0]    xdata_t;
    typedef logic [`AREG_W-1:0]  areg_t;
    typedef logic [`PREG_W-1:0]  preg_t;
    typedef logic [`PADDR_W-1:0] paddr_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL,
        OP_DIVU,
        OP_REMU
    } op_e;

endpackage

// File: exec/alu_station.sv
module alu_station (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dispatch,
    input  ooo_pkg::op_e    op,
    input  ooo_pkg::preg_t  src1_tag, src2_tag, dst_tag, old_tag,
    input  ooo_pkg::xdata_t src1_data, src2_data,
    input  logic            src1_valid, src2_valid,
    output logic            busy, wb_req,
    input  logic            wb_grant,
    input  logic            wb_valid,
    input  ooo_pkg::preg_t  wb_tag,
    input  ooo_pkg::xdata_t wb_data,
    output ooo_pkg::xdata_t res_data,
    output ooo_pkg::preg_t  res_tag, res_old_tag
);
    import ooo_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_DONE} state_e;

    state_e state_q;
    op_e    op_q;
    preg_t  tag1_q;
    preg_t  tag2_q;
    xdata_t opnd1_q;
    xdata_t opnd2_q;
    logic   rdy1_q;
    logic   rdy2_q;
    logic   hit1;
    logic   hit2;
    xdata_t alu_out;

    // wakeup only for an operand still missing
    assign hit1 = (state_q == ST_WAIT) && !rdy1_q && wb_valid && (wb_tag == tag1_q);
    assign hit2 = (state_q == ST_WAIT) && !rdy2_q && wb_valid && (wb_tag == tag2_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            rdy1_q  <= 1'b0;
            rdy2_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: if (dispatch) begin
                    state_q <= ST_WAIT;
                    rdy1_q  <= src1_valid || (wb_valid && wb_tag == src1_tag);
                    rdy2_q  <= src2_valid || (wb_valid && wb_tag == src2_tag);
                end
                ST_WAIT: begin
                    if (hit1) rdy1_q <= 1'b1;
                    if (hit2) rdy2_q <= 1'b1;
                    if (rdy1_q && rdy2_q) state_q <= ST_DONE;
                end
                ST_DONE: if (wb_grant) state_q <= ST_IDLE;     // hold result until granted
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            op_q        <= op;
            tag1_q      <= src1_tag;
            tag2_q      <= src2_tag;
            res_tag     <= dst_tag;
            res_old_tag <= old_tag;
            opnd1_q     <= src1_valid ? src1_data : wb_data;
            opnd2_q     <= src2_valid ? src2_data : wb_data;
        end else begin
            if (hit1) opnd1_q <= wb_data;
            if (hit2) opnd2_q <= wb_data;
        end
        if (state_q == ST_WAIT && rdy1_q && rdy2_q) begin
            res_data <= alu_out;
        end
    end

    always_comb begin
        case (op_q)
            OP_SUB:  alu_out = opnd1_q - opnd2_q;
            OP_AND:  alu_out = opnd1_q & opnd2_q;
            OP_OR:   alu_out = opnd1_q | opnd2_q;
            OP_XOR:  alu_out = opnd1_q ^ opnd2_q;
            default: alu_out = opnd1_q + opnd2_q;
        endcase
    end

    assign busy   = (state_q != ST_IDLE);
    assign wb_req = (state_q == ST_DONE);

endmodule

// File: exec/muldiv_unit.sv
`include "ooo_consts.svh"

module muldiv_unit (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dispatch,
    input  ooo_pkg::op_e    op,
    input  ooo_pkg::preg_t  src1_tag, src2_tag, dst_tag, old_tag,
    input  ooo_pkg::xdata_t src1_data, src2_data,
    input  logic            src1_valid, src2_valid,
    output logic            busy, wb_req,
    input  logic            wb_grant,
    input  logic            wb_valid,
    input  ooo_pkg::preg_t  wb_tag,
    input  ooo_pkg::xdata_t wb_data,
    output ooo_pkg::xdata_t res_data,
    output ooo_pkg::preg_t  res_tag, res_old_tag
);
    import ooo_pkg::*;

    localparam int CNT_W = $clog2(`MULDIV_CYCLES);

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_RUN, ST_DONE} state_e;

    state_e         state_q;
    op_e            op_q;
    preg_t          tag1_q;
    preg_t          tag2_q;
    logic           rdy1_q;
    logic           rdy2_q;
    logic           hit1;
    logic           hit2;
    logic [CNT_W-1:0] cnt_q;
    xdata_t         a_q;        // multiplier, or dividend shifting into quotient
    xdata_t         b_q;        // multiplicand or divisor
    xdata_t         acc_q;      // product or remainder
    logic [`XLEN:0] rem_shift;
    logic           div_ge;

    assign hit1 = (state_q == ST_WAIT) && !rdy1_q && wb_valid && (wb_tag == tag1_q);
    assign hit2 = (state_q == ST_WAIT) && !rdy2_q && wb_valid && (wb_tag == tag2_q);

    // restoring step; a zero divisor gives all ones and the dividend back
    assign rem_shift = {acc_q, a_q[`XLEN-1]};
    assign div_ge    = (rem_shift >= {1'b0, b_q});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            rdy1_q  <= 1'b0;
            rdy2_q  <= 1'b0;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: if (dispatch) begin
                    state_q <= ST_WAIT;
                    rdy1_q  <= src1_valid || (wb_valid && wb_tag == src1_tag);
                    rdy2_q  <= src2_valid || (wb_valid && wb_tag == src2_tag);
                end
                ST_WAIT: begin
                    if (hit1) rdy1_q <= 1'b1;
                    if (hit2) rdy2_q <= 1'b1;
                    if (rdy1_q && rdy2_q) begin
                        state_q <= ST_RUN;
                        cnt_q   <= '0;
                    end
                end
                ST_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`MULDIV_CYCLES - 1)) state_q <= ST_DONE;
                end
                ST_DONE: if (wb_grant) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            op_q        <= op;
            tag1_q      <= src1_tag;
            tag2_q      <= src2_tag;
            res_tag     <= dst_tag;
            res_old_tag <= old_tag;
            a_q         <= src1_valid ? src1_data : wb_data;
            b_q         <= src2_valid ? src2_data : wb_data;
        end else if (state_q == ST_WAIT) begin
            if (hit1) a_q <= wb_data;
            if (hit2) b_q <= wb_data;
            acc_q <= '0;
        end else if (state_q == ST_RUN) begin
            if (op_q == OP_MUL) begin
                if (a_q[0]) acc_q <= acc_q + b_q;   // low half only
                a_q <= a_q >> 1;
                b_q <= b_q << 1;
            end else begin
                acc_q <= div_ge ? xdata_t'(rem_shift - {1'b0, b_q}) : rem_shift[`XLEN-1:0];
                a_q   <= {a_q[`XLEN-2:0], div_ge};
            end
        end
    end

    assign res_data = (op_q == OP_DIVU) ? a_q : acc_q;
    assign busy     = (state_q != ST_IDLE);
    assign wb_req   = (state_q == ST_DONE);

endmodule

// File: ooo_core.f
+incdir+common
common/ooo_pkg.sv
rtl/issue_ctrl.sv
rename/rename_table.sv
rename/free_list.sv
rtl/phys_regfile.sv
exec/alu_station.sv
exec/muldiv_unit.sv
rtl/ooo_core_top.sv
verif/ooo_checker.sv
verif/tb_ooo_core.sv

// File: rename/free_list.sv
`include "ooo_consts.svh"

module free_list (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           pop,
    output ooo_pkg::preg_t head_tag,
    output logic           empty,
    input  logic           wb_valid,
    input  ooo_pkg::preg_t wb_free_tag
);
    import ooo_pkg::*;

    localparam int DEPTH = `PHYS_REGS - `ARCH_REGS;
    localparam int PTR_W = $clog2(DEPTH);

    preg_t            fifo_q [DEPTH];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                fifo_q[i] <= preg_t'(`ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;      // full, tail wraps onto head
            count_q <= (PTR_W+1)'(DEPTH);
        end else begin
            if (wb_valid) begin
                fifo_q[tail_q] <= wb_free_tag;
                tail_q         <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end
            if (wb_valid && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !wb_valid) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign head_tag = fifo_q[head_q];
    assign empty    = (count_q == '0);

endmodule

// File: rename/rename_table.sv
`include "ooo_consts.svh"

module rename_table (
    input  logic           clk,
    input  logic           rst_n,
    input  ooo_pkg::areg_t rs1, rs2, rd,
    input  ooo_pkg::areg_t xsel,
    input  logic           rename_we,
    input  ooo_pkg::preg_t new_tag,
    output ooo_pkg::preg_t src1_tag, src2_tag,
    output ooo_pkg::preg_t old_tag,
    output ooo_pkg::preg_t xsel_tag
);
    import ooo_pkg::*;

    preg_t map_q [`ARCH_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= preg_t'(i);     // x[i] -> p[i]
            end
        end else if (rename_we) begin
            map_q[rd] <= new_tag;
        end
    end

    // lookups see the table before this cycle's rename
    assign src1_tag = map_q[rs1];
    assign src2_tag = map_q[rs2];
    assign old_tag  = map_q[rd];
    assign xsel_tag = map_q[xsel];

endmodule

// File: rtl/issue_ctrl.sv
`include "ooo_consts.svh"

module issue_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            psel, penable, pwrite,
    input  ooo_pkg::paddr_t paddr,
    input  ooo_pkg::xdata_t pwdata,
    output logic            pready, pslverr,
    output ooo_pkg::xdata_t prdata,
    output ooo_pkg::areg_t  rs1, rs2, rd,
    output ooo_pkg::op_e    op,
    output logic            alu_dispatch, md_dispatch,
    input  logic            alu_busy, md_busy,
    input  logic            fl_empty,
    input  logic            rd_map_valid,
    input  logic            xread_valid,
    input  ooo_pkg::xdata_t xread_data,
    input  logic            alu_req, md_req,
    output logic            alu_grant, md_grant,
    output logic            rename_we
);
    import ooo_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    op_e        op_dec;
    logic       legal_dec;
    logic       issue_q;        // legal instruction write
    logic       xread_q;        // read inside the x window
    logic       access;
    logic       is_md;
    logic       unit_busy;
    logic       can_issue;
    logic       issue_done;

    assign opcode = pwdata[6:0];
    assign funct3 = pwdata[14:12];
    assign funct7 = pwdata[31:25];

    always_comb begin
        op_dec    = OP_ADD;
        legal_dec = (opcode == `OPC_OP);
        case ({funct7, funct3})
            {`F7_BASE, `F3_ADD}:    op_dec = OP_ADD;
            {`F7_SUB, `F3_ADD}:     op_dec = OP_SUB;
            {`F7_BASE, `F3_AND}:    op_dec = OP_AND;
            {`F7_BASE, `F3_OR}:     op_dec = OP_OR;
            {`F7_BASE, `F3_XOR}:    op_dec = OP_XOR;
            {`F7_MULDIV, `F3_MUL}:  op_dec = OP_MUL;
            {`F7_MULDIV, `F3_DIVU}: op_dec = OP_DIVU;
            {`F7_MULDIV, `F3_REMU}: op_dec = OP_REMU;
            default:                legal_dec = 1'b0;
        endcase
    end

    // decode is taken in the setup phase, access only checks stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_q <= 1'b0;
            xread_q <= 1'b0;
            op      <= OP_ADD;
            rs1     <= '0;
            rs2     <= '0;
            rd      <= '0;
        end else if (psel && !penable) begin
            issue_q <= pwrite && (paddr == `ADDR_ISSUE) && legal_dec;
            xread_q <= !pwrite && ((paddr & ~`ADDR_XREG_MASK) == `ADDR_XREG_BASE);
            op      <= op_dec;
            rs1     <= pwdata[19:15];
            rs2     <= pwdata[24:20];
            rd      <= pwdata[11:7];
        end
    end

    assign access    = psel && penable;
    assign is_md     = op inside {OP_MUL, OP_DIVU, OP_REMU};
    assign unit_busy = is_md ? md_busy : alu_busy;

    // x0 as target retires at once, nothing renamed
    assign can_issue  = (rd == '0) || (!unit_busy && !fl_empty && rd_map_valid);
    assign issue_done = access && issue_q && can_issue;

    assign rename_we    = issue_done && (rd != '0);
    assign alu_dispatch = rename_we && !is_md;
    assign md_dispatch  = rename_we && is_md;

    assign pslverr = access && !(issue_q || xread_q);
    assign pready  = issue_done || (access && xread_q && xread_valid) || pslverr;
    assign prdata  = (access && xread_q) ? xread_data : '0;

    // fixed priority, alu first
    assign alu_grant = alu_req;
    assign md_grant  = md_req && !alu_req;

endmodule

// File: rtl/ooo_core_top.sv
module ooo_core_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            psel, penable, pwrite,
    input  ooo_pkg::paddr_t paddr,
    input  ooo_pkg::xdata_t pwdata,
    output ooo_pkg::xdata_t prdata,
    output logic            pready, pslverr
);
    import ooo_pkg::*;

    areg_t  rs1, rs2, rd;
    areg_t  xsel;
    op_e    op;
    logic   alu_dispatch, md_dispatch, rename_we;
    logic   alu_busy, md_busy;
    logic   alu_req, md_req, alu_grant, md_grant;
    logic   fl_empty;
    preg_t  head_tag;
    preg_t  src1_tag, src2_tag, old_tag, xsel_tag;
    xdata_t src1_data, src2_data, xread_data;
    logic   src1_valid, src2_valid, xread_valid;
    logic   wb_valid;
    preg_t  wb_tag, wb_free_tag;
    xdata_t wb_data;
    xdata_t alu_res_data, md_res_data;
    preg_t  alu_res_tag, md_res_tag;
    preg_t  alu_res_old, md_res_old;

    // on an issue the third read port checks rd's current mapping
    assign xsel = pwrite ? rd : paddr[6:2];

    // writeback bus from the granted unit
    assign wb_valid    = alu_grant || md_grant;
    assign wb_tag      = alu_grant ? alu_res_tag  : md_res_tag;
    assign wb_data     = alu_grant ? alu_res_data : md_res_data;
    assign wb_free_tag = alu_grant ? alu_res_old  : md_res_old;

    issue_ctrl u_issue_ctrl (
        .rd_map_valid (xread_valid),
        .*
    );

    rename_table u_rename_table (
        .new_tag (head_tag),
        .*
    );

    free_list u_free_list (
        .pop   (rename_we),
        .empty (fl_empty),
        .*
    );

    phys_regfile u_phys_regfile (
        .alloc     (rename_we),
        .alloc_tag (head_tag),
        .*
    );

    alu_station u_alu_station (
        .dispatch    (alu_dispatch),
        .dst_tag     (head_tag),
        .busy        (alu_busy),
        .wb_req      (alu_req),
        .wb_grant    (alu_grant),
        .res_data    (alu_res_data),
        .res_tag     (alu_res_tag),
        .res_old_tag (alu_res_old),
        .*
    );

    muldiv_unit u_muldiv_unit (
        .dispatch    (md_dispatch),
        .dst_tag     (head_tag),
        .busy        (md_busy),
        .wb_req      (md_req),
        .wb_grant    (md_grant),
        .res_data    (md_res_data),
        .res_tag     (md_res_tag),
        .res_old_tag (md_res_old),
        .*
    );

endmodule

// File: rtl/phys_regfile.sv
`include "ooo_consts.svh"

module phys_regfile (
    input  logic            clk,
    input  logic            rst_n,
    input  ooo_pkg::preg_t  src1_tag, src2_tag, xsel_tag,
    output ooo_pkg::xdata_t src1_data, src2_data, xread_data,
    output logic            src1_valid, src2_valid, xread_valid,
    input  logic            alloc,
    input  ooo_pkg::preg_t  alloc_tag,
    input  logic            wb_valid,
    input  ooo_pkg::preg_t  wb_tag,
    input  ooo_pkg::xdata_t wb_data
);
    import ooo_pkg::*;

    xdata_t                data_q [`PHYS_REGS];
    logic [`PHYS_REGS-1:0] valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                data_q[i] <= '0;
            end
            // identity-mapped tags start out valid
            valid_q <= {{(`PHYS_REGS - `ARCH_REGS){1'b0}}, {`ARCH_REGS{1'b1}}};
        end else begin
            if (alloc) begin
                valid_q[alloc_tag] <= 1'b0;
            end
            if (wb_valid) begin
                valid_q[wb_tag] <= 1'b1;
                data_q[wb_tag]  <= wb_data;
            end
        end
    end

    assign src1_data   = data_q[src1_tag];
    assign src2_data   = data_q[src2_tag];
    assign xread_data  = data_q[xsel_tag];
    assign src1_valid  = valid_q[src1_tag];
    assign src2_valid  = valid_q[src2_tag];
    assign xread_valid = valid_q[xsel_tag];

endmodule

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f ooo_core.f --top-module tb_ooo_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_ooo_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: verif/ooo_checker.sv
module ooo_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            psel, penable, pwrite,
    input  logic            pready, pslverr,
    input  ooo_pkg::paddr_t paddr,
    input  ooo_pkg::xdata_t prdata,
    output int              tests_done,
    output int              tests_failed
);
    timeunit 1ns;
    timeprecision 100ps;

    import ooo_pkg::*;

    localparam string DATA_FILE = "verif/ooo_testdata.txt";

    logic   err_q[$];
    xdata_t rdata_q[$];
    int     count_q[$];
    int     line_q[$];
    int     idx      = 0;
    int     seen     = 0;       // transfers done for the current line
    logic   cur_bad  = 1'b0;
    int     n_done   = 0;
    int     n_failed = 0;

    assign tests_done   = n_done;
    assign tests_failed = n_failed;

    task automatic load_expected();
        int          fd;
        int          line_no;
        string       line;
        logic [31:0] f_wr, f_addr, f_data, f_cnt, f_err, f_rdata;
        line_no = 0;
        fd      = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("checker cannot open %s, no transfer can be checked", DATA_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            line_no++;
            if ($sscanf(line, "%h %h %h %h %h %h",
                        f_wr, f_addr, f_data, f_cnt, f_err, f_rdata) == 6) begin
                err_q.push_back(f_err[0]);
                rdata_q.push_back(f_rdata);
                count_q.push_back(int'(f_cnt));
                line_q.push_back(line_no);
            end
        end
        $fclose(fd);
    endtask

    initial load_expected();

    task automatic check_transfer();
        if (idx >= err_q.size()) begin
            $display("unexpected APB transfer to paddr %h at %0.1f ns, no entry left to match",
                     paddr, $realtime);
            n_failed++;
            return;
        end
        if (pslverr !== err_q[idx]) begin
            $display("FAILED at %0.1f ns: pslverr = %b, expected %b", $realtime, pslverr,
                     err_q[idx]);
            cur_bad = 1'b1;
        end
        if (prdata !== rdata_q[idx]) begin
            $display("FAILED at %0.1f ns: prdata = %h, expected %h", $realtime, prdata,
                     rdata_q[idx]);
            cur_bad = 1'b1;
        end
        seen++;
        if (seen == count_q[idx]) begin
            if (cur_bad) begin
                $display("test %0d (line %0d, %s): mismatch", idx + 1, line_q[idx],
                         pwrite ? "write" : "read");
                n_failed++;
            end else begin
                $display("test %0d (line %0d, %s): ok", idx + 1, line_q[idx],
                         pwrite ? "write" : "read");
            end
            n_done++;
            idx++;
            seen    = 0;
            cur_bad = 1'b0;
        end
    endtask

    // pready is settled by mid cycle
    always @(negedge clk) begin
        if (rst_n && psel && penable && pready) begin
            check_transfer();
        end
    end

endmodule

// File: verif/ooo_testdata.txt
# pwrite paddr pwdata count pslverr prdata, every field in hex
# count repeats the transfer, repeated reads step paddr by 4
0 100 00000000 20 0 00000000
1 000 020050b3 1 0 00000000
1 000 40100133 1 0 00000000
1 000 002101b3 1 0 00000000
1 000 00218233 1 0 00000000
1 000 024082b3 1 0 00000000
1 000 02528333 1 0 00000000
1 000 0062c3b3 1 0 00000000
1 000 0043e433 1 0 00000000
1 000 006474b3 1 0 00000000
0 104 00000000 1 0 ffffffff
0 108 00000000 1 0 00000001
0 110 00000000 1 0 00000003
0 114 00000000 1 0 fffffffd
0 118 00000000 1 0 00000009
0 11c 00000000 1 0 fffffff4
0 120 00000000 1 0 fffffff7
0 124 00000000 1 0 00000001
1 000 0242d533 1 0 00000000
1 000 0242f5b3 1 0 00000000
1 000 02037633 1 0 00000000
1 000 020356b3 1 0 00000000
1 000 0262f733 1 0 00000000
1 000 0262d7b3 1 0 00000000
0 128 00000000 1 0 55555554
0 12c 00000000 1 0 00000001
0 130 00000000 1 0 00000009
0 134 00000000 1 0 ffffffff
0 138 00000000 1 0 00000001
0 13c 00000000 1 0 1c71c71c
1 000 0242d833 1 0 00000000
1 000 004188b3 1 0 00000000
1 000 00280933 1 0 00000000
0 144 00000000 1 0 00000005
0 148 00000000 1 0 55555555
0 140 00000000 1 0 55555554
1 000 024209b3 1 0 00000000
1 000 024989b3 2 0 00000000
0 14c 00000000 1 0 00000051
1 000 002a0a33 30 0 00000000
0 150 00000000 1 0 00000030
1 000 00318033 1 0 00000000
0 100 00000000 1 0 00000000
1 000 00000093 1 1 00000000
1 000 4031c133 1 1 00000000
1 200 00318133 1 1 00000000
0 080 00000000 1 1 00000000
1 104 00318133 1 1 00000000
0 104 00000000 1 0 ffffffff
0 108 00000000 1 0 00000001
0 10c 00000000 1 0 00000002

// File: verif/tb_ooo_core.sv
module tb_ooo_core;
    timeunit 1ns;
    timeprecision 100ps;

    import ooo_pkg::*;

    localparam int    CLK_PERIOD      = 8;
    localparam int    RESET_CYCLES    = 16;
    localparam int    CYCLES_PER_XFER = 64;
    localparam string DATA_FILE       = "verif/ooo_testdata.txt";

    logic   clk;
    logic   rst_n;
    logic   psel;
    logic   penable;
    logic   pwrite;
    paddr_t paddr;
    xdata_t pwdata;
    xdata_t prdata;
    logic   pready;
    logic   pslverr;
    int     tests_done;
    int     tests_failed;

    logic   wr_q[$];
    paddr_t addr_q[$];
    xdata_t data_q[$];
    int     count_q[$];
    int     total_xfers = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    ooo_core_top u_ooo_core_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    ooo_checker u_ooo_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pready       (pready),
        .pslverr      (pslverr),
        .paddr        (paddr),
        .prdata       (prdata),
        .tests_done   (tests_done),
        .tests_failed (tests_failed)
    );

    task automatic load_stimulus();
        int          fd;
        int          sum;
        string       line;
        logic [31:0] f_wr, f_addr, f_data, f_cnt, f_err, f_rdata;
        sum = 0;
        fd  = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // comment and blank lines do not scan
            if ($sscanf(line, "%h %h %h %h %h %h",
                        f_wr, f_addr, f_data, f_cnt, f_err, f_rdata) == 6) begin
                wr_q.push_back(f_wr[0]);
                addr_q.push_back(paddr_t'(f_addr));
                data_q.push_back(f_data);
                count_q.push_back(int'(f_cnt));
                sum += int'(f_cnt);
            end
        end
        $fclose(fd);
        total_xfers = sum;
    endtask

    // setup, access, then hold until pready
    task automatic apb_transfer(input logic wr, input paddr_t addr, input xdata_t data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        load_stimulus();
        if (wr_q.size() == 0) begin
            $display("no stimulus could be read from %s", DATA_FILE);
            $display("test failed");
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            rst_n <= 1'b1;
            foreach (wr_q[n]) begin
                for (int r = 0; r < count_q[n]; r++) begin
                    // repeated reads walk the x window
                    apb_transfer(wr_q[n], wr_q[n] ? addr_q[n] : addr_q[n] + paddr_t'(4 * r),
                                 data_q[n]);
                end
            end
            repeat (4) @(posedge clk);
            $display("%0d of %0d tests done, %0d failed", tests_done, wr_q.size(),
                     tests_failed);
            if (tests_failed == 0 && tests_done == wr_q.size()) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
        end
        $finish;
    end

    initial begin : watchdog
        wait (total_xfers > 0);
        repeat (RESET_CYCLES + total_xfers * CYCLES_PER_XFER) @(posedge clk);
        $display("timeout: %0d APB transfers did not finish within %0d cycles", total_xfers,
                 RESET_CYCLES + total_xfers * CYCLES_PER_XFER);
        $display("test failed");
        $finish;
    end

endmodule
